/* rs_main_control.f */
+incdir+include
verilog/rs_decode_state_pkg.sv
verilog/rs_transfer_state_pkg.sv
verilog/rs_decode_sequencer.sv
verilog/rs_word_transfer.sv
verilog/rs_main_control.sv
dv/rs_main_control_tb.sv

/* dv/rs_main_control_tb.sv */
`timescale 1ns/1ns

`include "rs_control_config.svh"

module rs_main_control_tb;

   localparam int NUM_TESTS = 7;
   localparam int WATCHDOG_CYCLES = NUM_TESTS * (2 * `RS_WORD_LEN + 40);

   // Event counts gathered over one test
   typedef struct packed {
      logic [7:0] evalsynd;
      logic [7:0] errfound;
      logic [7:0] kes_runs;
      logic [7:0] csee;
      logic [7:0] fail;
      logic [7:0] outstart;
      logic [7:0] outend;
      logic [7:0] infifo;
      logic [7:0] evalerror;
      logic [7:0] overlap;
   } event_counts_t;

   logic                        clock1;
   logic                        reset;
   logic                        start;
   logic                        errdetect;
   logic                        finish_kes;
   logic [`RS_DEGREE_WIDTH-1:0] rootcntr;
   logic [`RS_DEGREE_WIDTH-1:0] lambda_degree;
   logic                        ready;
   logic                        active_sc;
   logic                        active_kes;
   logic                        active_csee;
   logic                        evalsynd;
   logic                        holdsynd;
   logic                        errfound;
   logic                        decode_fail;
   logic                        dataoutstart;
   logic                        dataoutend;
   logic                        shift_fifo;
   logic                        hold_fifo;
   logic                        en_infifo;
   logic                        en_outfifo;
   logic                        lastdataout;
   logic                        evalerror;

   logic [31:0]   lfsr_state;
   event_counts_t expected;
   event_counts_t observed;
   logic          check_req;
   string         test_name;
   int            error_count;
   int            test_errors_base;
   int            test_count;
   int            failed_tests;
   int            error_run;
   logic          kes_prev;
   logic          outend_prev;

   rs_main_control u_dut (
      .clock1        (clock1),
      .reset         (reset),
      .start         (start),
      .errdetect     (errdetect),
      .finish_kes    (finish_kes),
      .rootcntr      (rootcntr),
      .lambda_degree (lambda_degree),
      .ready         (ready),
      .active_sc     (active_sc),
      .active_kes    (active_kes),
      .active_csee   (active_csee),
      .evalsynd      (evalsynd),
      .holdsynd      (holdsynd),
      .errfound      (errfound),
      .decode_fail   (decode_fail),
      .dataoutstart  (dataoutstart),
      .dataoutend    (dataoutend),
      .shift_fifo    (shift_fifo),
      .hold_fifo     (hold_fifo),
      .en_infifo     (en_infifo),
      .en_outfifo    (en_outfifo),
      .lastdataout   (lastdataout),
      .evalerror     (evalerror)
   );

   always #4 clock1 = ~clock1;

   function automatic logic [31:0] lfsr_next(input logic [31:0] value);
      if (value[0]) begin
         return (value >> 1) ^ 32'h8020_0003;
      end
      return value >> 1;
   endfunction

   // One LFSR step for every bit taken
   task automatic random_bits(input int count, output logic [7:0] value);
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[6:0], lfsr_state[0]};
      end
   endtask

   // Expected events of one decoded word
   function automatic event_counts_t expected_word(input logic err, input logic match,
                                                   input logic overlapped);
      event_counts_t result;
      result           = '0;
      result.evalsynd  = 8'd1;
      result.errfound  = {7'd0, err};
      result.kes_runs  = {7'd0, err};
      result.csee      = {7'd0, err};
      // Roots are compared with the degree only after a correction
      result.fail      = {7'd0, err && !match};
      result.outstart  = 8'd1;
      result.outend    = 8'd1;
      result.infifo    = 8'(`RS_WORD_LEN + 1);
      result.evalerror = 8'(`RS_DATAOUT_LAST + 1);
      result.overlap   = {7'd0, overlapped};
      return result;
   endfunction

   function automatic event_counts_t add_counts(input event_counts_t a, input event_counts_t b);
      event_counts_t sum;
      sum.evalsynd  = a.evalsynd + b.evalsynd;
      sum.errfound  = a.errfound + b.errfound;
      sum.kes_runs  = a.kes_runs + b.kes_runs;
      sum.csee      = a.csee + b.csee;
      sum.fail      = a.fail + b.fail;
      sum.outstart  = a.outstart + b.outstart;
      sum.outend    = a.outend + b.outend;
      sum.infifo    = a.infifo + b.infifo;
      sum.evalerror = a.evalerror + b.evalerror;
      sum.overlap   = a.overlap + b.overlap;
      return sum;
   endfunction

   task automatic show_mismatch(input string sig, input int exp_value, input int act_value);
      $display("Fail at %0t ns: %s expected %0d actual %0d", $time, sig, exp_value, act_value);
      error_count++;
   endtask

   // Key equation solver answers after 1 to 16 cycles
   always begin : kes_model
      logic [7:0] bits;
      int         delay;
      @(posedge clock1);
      if (reset && active_kes) begin
         random_bits(4, bits);
         delay = bits[3:0] + 1;
         repeat (delay) @(posedge clock1);
         finish_kes <= 1'b1;
         @(posedge clock1);
         finish_kes <= 1'b0;
         while (active_kes) begin
            @(posedge clock1);
         end
      end
   end

   // Cycle monitor that counts events and checks the per-cycle rules
   always @(posedge clock1) begin
      if (reset) begin
         if (shift_fifo && hold_fifo) begin
            $display("Error at %0t ns: shift_fifo and hold_fifo are high together", $time);
            error_count++;
         end
         if (finish_kes && !active_kes) begin
            $display("Error at %0t ns: finish_kes came while active_kes was low", $time);
            error_count++;
         end
         if (decode_fail && (!ready || !outend_prev)) begin
            $display("Error at %0t ns: decode_fail rose without dataoutend or ready", $time);
            error_count++;
         end
         // Terminal output count marks the last cycle of the evalerror run
         if (lastdataout != (evalerror && error_run == `RS_DATAOUT_LAST)) begin
            show_mismatch("lastdataout", evalerror && error_run == `RS_DATAOUT_LAST,
                          lastdataout);
         end
         if (evalerror) begin
            error_run++;
         end else if (error_run != 0) begin
            if (error_run != `RS_DATAOUT_LAST + 1) begin
               show_mismatch("evalerror run", `RS_DATAOUT_LAST + 1, error_run);
            end
            if (!dataoutend) begin
               show_mismatch("dataoutend after evalerror", 1, dataoutend);
            end
            error_run = 0;
         end
         observed.evalsynd  = observed.evalsynd + evalsynd;
         observed.errfound  = observed.errfound + errfound;
         observed.kes_runs  = observed.kes_runs + (active_kes && !kes_prev);
         observed.csee      = observed.csee + active_csee;
         observed.fail      = observed.fail + decode_fail;
         observed.outstart  = observed.outstart + dataoutstart;
         observed.outend    = observed.outend + dataoutend;
         observed.infifo    = observed.infifo + en_infifo;
         observed.evalerror = observed.evalerror + evalerror;
         observed.overlap   = observed.overlap + (active_sc && en_outfifo);
         kes_prev    = active_kes;
         outend_prev = dataoutend;
      end
   end

   // End of test comparison against the reference counts
   always begin : compare_counts
      wait (check_req);
      if (observed.evalsynd != expected.evalsynd) begin
         show_mismatch("evalsynd pulses", expected.evalsynd, observed.evalsynd);
      end
      if (observed.errfound != expected.errfound) begin
         show_mismatch("errfound pulses", expected.errfound, observed.errfound);
      end
      if (observed.kes_runs != expected.kes_runs) begin
         show_mismatch("active_kes runs", expected.kes_runs, observed.kes_runs);
      end
      if (observed.csee != expected.csee) begin
         show_mismatch("active_csee pulses", expected.csee, observed.csee);
      end
      if (observed.fail != expected.fail) begin
         show_mismatch("decode_fail cycles", expected.fail, observed.fail);
      end
      if (observed.outstart != expected.outstart) begin
         show_mismatch("dataoutstart pulses", expected.outstart, observed.outstart);
      end
      if (observed.outend != expected.outend) begin
         show_mismatch("dataoutend pulses", expected.outend, observed.outend);
      end
      if (observed.infifo != expected.infifo) begin
         show_mismatch("en_infifo cycles", expected.infifo, observed.infifo);
      end
      if (observed.evalerror != expected.evalerror) begin
         show_mismatch("evalerror cycles", expected.evalerror, observed.evalerror);
      end
      if (observed.overlap != expected.overlap) begin
         show_mismatch("active_sc during output", expected.overlap, observed.overlap);
      end
      test_count++;
      if (error_count == test_errors_base) begin
         $display("Test %s: ok", test_name);
      end else begin
         failed_tests++;
         $display("Test %s: %0d errors", test_name, error_count - test_errors_base);
      end
      observed  = '0;
      check_req = 1'b0;
   end

   // Offer a word and hold start until reception opens
   task automatic offer_word(input logic err, input logic [2:0] roots, input logic [2:0] degree);
      @(posedge clock1);
      errdetect     <= err;
      rootcntr      <= roots;
      lambda_degree <= degree;
      start         <= 1'b1;
      do begin
         @(posedge clock1);
      end while (!active_sc);
      start <= 1'b0;
   endtask

   task automatic wait_dataoutend();
      do begin
         @(posedge clock1);
      end while (!dataoutend);
   endtask

   task automatic finish_test();
      repeat (2) @(posedge clock1);
      if (!ready) begin
         $display("Error at %0t ns: ready did not return after the word", $time);
         error_count++;
      end
      @(negedge clock1);
      check_req = 1'b1;
      wait (!check_req);
   endtask

   task automatic run_word_test(input string name, input logic err,
                                input logic [2:0] roots, input logic [2:0] degree);
      test_name        = name;
      test_errors_base = error_count;
      expected         = expected_word(err, roots == degree, 1'b0);
      offer_word(err, roots, degree);
      wait_dataoutend();
      finish_test();
   endtask

   initial begin
      logic [14:0] others;
      logic [7:0]  bits;
      logic [2:0]  degree;
      clock1        = 1'b0;
      reset         = 1'b0;
      start         = 1'b0;
      errdetect     = 1'b0;
      finish_kes    = 1'b0;
      rootcntr      = '0;
      lambda_degree = '0;
      lfsr_state    = 32'h487e_fe18;
      observed      = '0;
      expected      = '0;
      check_req     = 1'b0;
      error_count   = 0;
      test_count    = 0;
      failed_tests  = 0;
      error_run     = 0;
      kes_prev      = 1'b0;
      outend_prev   = 1'b0;
      repeat (4) @(posedge clock1);
      reset <= 1'b1;

      // Idle controller after reset
      test_name        = "reset";
      test_errors_base = error_count;
      repeat (2) @(posedge clock1);
      others = {active_sc, active_kes, active_csee, evalsynd, holdsynd, errfound, decode_fail,
                dataoutstart, dataoutend, shift_fifo, hold_fifo, en_infifo, en_outfifo,
                lastdataout, evalerror};
      if (!ready) begin
         show_mismatch("ready", 1, ready);
      end
      if (others != '0) begin
         show_mismatch("other control outputs", 0, others);
      end
      finish_test();

      run_word_test("clean_word", 1'b0, 3'd2, 3'd2);
      run_word_test("corrected_word", 1'b1, 3'd3, 3'd3);
      run_word_test("degree_mismatch", 1'b1, 3'd2, 3'd3);

      // Second word offered while the first one drains
      test_name        = "back_to_back";
      test_errors_base = error_count;
      expected         = add_counts(expected_word(1'b1, 1'b1, 1'b1),
                                    expected_word(1'b0, 1'b1, 1'b0));
      offer_word(1'b1, 3'd4, 3'd4);
      do begin
         @(posedge clock1);
      end while (!dataoutstart);
      offer_word(1'b0, 3'd4, 3'd4);
      wait_dataoutend();
      wait_dataoutend();
      finish_test();

      for (int n = 0; n < 2; n++) begin
         random_bits(5, bits);
         degree = bits[2:0];
         run_word_test($sformatf("random_%0d", n), bits[4], bits[3] ? degree ^ 3'd1 : degree,
                       degree);
      end

      $display("Tests run %0d, tests failed %0d, errors %0d", test_count, failed_tests,
               error_count);
      if (error_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      rs_decode_state_pkg::decode_state_t stuck_state;
      repeat (WATCHDOG_CYCLES) @(posedge clock1);
      stuck_state = u_dut.u_decode_sequencer.state;
      $display("Timeout: run did not end within %0d cycles, decode sequencer in state %s",
               WATCHDOG_CYCLES, stuck_state.name());
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* verilog/rs_main_control.sv */
`timescale 1ns/1ns

`include "rs_control_config.svh"

module rs_main_control (
   input  logic                        clock1,
   input  logic                        reset,
   input  logic                        start,
   input  logic                        errdetect,
   input  logic                        finish_kes,
   input  logic [`RS_DEGREE_WIDTH-1:0] rootcntr,
   input  logic [`RS_DEGREE_WIDTH-1:0] lambda_degree,
   output logic                        ready,
   output logic                        active_sc,
   output logic                        active_kes,
   output logic                        active_csee,
   output logic                        evalsynd,
   output logic                        holdsynd,
   output logic                        errfound,
   output logic                        decode_fail,
   output logic                        dataoutstart,
   output logic                        dataoutend,
   output logic                        shift_fifo,
   output logic                        hold_fifo,
   output logic                        en_infifo,
   output logic                        en_outfifo,
   output logic                        lastdataout,
   output logic                        evalerror
);

   // Reception end, seen only between the two sequencers
   logic datain_done;

   rs_decode_sequencer u_decode_sequencer (
      .clock1        (clock1),
      .reset         (reset),
      .start         (start),
      .datain_done   (datain_done),
      .errdetect     (errdetect),
      .finish_kes    (finish_kes),
      .dataoutend    (dataoutend),
      .rootcntr      (rootcntr),
      .lambda_degree (lambda_degree),
      .ready         (ready),
      .active_sc     (active_sc),
      .active_kes    (active_kes),
      .active_csee   (active_csee),
      .evalsynd      (evalsynd),
      .errfound      (errfound),
      .decode_fail   (decode_fail),
      .en_outfifo    (en_outfifo)
   );

   rs_word_transfer u_word_transfer (
      .clock1       (clock1),
      .reset        (reset),
      .active_sc    (active_sc),
      .en_outfifo   (en_outfifo),
      .datain_done  (datain_done),
      .dataoutstart (dataoutstart),
      .dataoutend   (dataoutend),
      .shift_fifo   (shift_fifo),
      .hold_fifo    (hold_fifo),
      .en_infifo    (en_infifo),
      .holdsynd     (holdsynd),
      .lastdataout  (lastdataout),
      .evalerror    (evalerror)
   );

endmodule

/* verilog/rs_word_transfer.sv */
`timescale 1ns/1ns

`include "rs_control_config.svh"

module rs_word_transfer (
   input  logic clock1,
   input  logic reset,
   input  logic active_sc,
   input  logic en_outfifo,
   output logic datain_done,
   output logic dataoutstart,
   output logic dataoutend,
   output logic shift_fifo,
   output logic hold_fifo,
   output logic en_infifo,
   output logic holdsynd,
   output logic lastdataout,
   output logic evalerror
);

   rs_transfer_state_pkg::transfer_state_t state;
   rs_transfer_state_pkg::transfer_state_t next_state;
   rs_transfer_state_pkg::symbol_count_t   cnt_in;
   rs_transfer_state_pkg::symbol_count_t   cnt_out;
   logic                                   cnt_in_en;
   logic                                   cnt_out_en;
   logic                                   in_last;

   assign in_last     = (cnt_in == rs_transfer_state_pkg::symbol_count_t'(`RS_DATAIN_LAST));
   assign lastdataout = (cnt_out == rs_transfer_state_pkg::symbol_count_t'(`RS_DATAOUT_LAST));

   // Output symbols are evaluated while the output counter runs
   assign evalerror = cnt_out_en;

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state <= rs_transfer_state_pkg::idle;
      end else begin
         state <= next_state;
      end
   end

   // Symbol counters restart from zero whenever their enable drops
   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         cnt_in  <= '0;
         cnt_out <= '0;
      end else begin
         cnt_in  <= cnt_in_en ? cnt_in + 1'b1 : '0;
         cnt_out <= cnt_out_en ? cnt_out + 1'b1 : '0;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         rs_transfer_state_pkg::idle: begin
            if (active_sc) begin
               next_state = rs_transfer_state_pkg::fill;
            end
         end
         rs_transfer_state_pkg::fill: begin
            if (in_last) begin
               next_state = rs_transfer_state_pkg::fill_last;
            end
         end
         rs_transfer_state_pkg::fill_last: begin
            next_state = rs_transfer_state_pkg::hold;
         end
         rs_transfer_state_pkg::hold: begin
            if (en_outfifo) begin
               next_state = rs_transfer_state_pkg::drain_start;
            end
         end
         rs_transfer_state_pkg::drain_start: begin
            if (active_sc) begin
               next_state = rs_transfer_state_pkg::overlap_start;
            end else begin
               next_state = rs_transfer_state_pkg::drain_first;
            end
         end
         rs_transfer_state_pkg::drain_first: begin
            if (active_sc) begin
               next_state = rs_transfer_state_pkg::overlap;
            end else begin
               next_state = rs_transfer_state_pkg::drain;
            end
         end
         rs_transfer_state_pkg::drain: begin
            if (active_sc) begin
               next_state = rs_transfer_state_pkg::overlap;
            end else if (lastdataout) begin
               next_state = rs_transfer_state_pkg::drain_end;
            end
         end
         rs_transfer_state_pkg::drain_end: begin
            // A new word may already be waiting at the end of output
            if (active_sc) begin
               next_state = rs_transfer_state_pkg::fill;
            end else begin
               next_state = rs_transfer_state_pkg::idle;
            end
         end
         rs_transfer_state_pkg::overlap_start: begin
            next_state = rs_transfer_state_pkg::overlap;
         end
         rs_transfer_state_pkg::overlap: begin
            if (lastdataout && in_last) begin
               next_state = rs_transfer_state_pkg::overlap_end_full;
            end else if (lastdataout) begin
               next_state = rs_transfer_state_pkg::overlap_end;
            end
         end
         rs_transfer_state_pkg::overlap_end_full: begin
            next_state = rs_transfer_state_pkg::hold;
         end
         rs_transfer_state_pkg::overlap_end: begin
            if (in_last) begin
               next_state = rs_transfer_state_pkg::fill_last;
            end else begin
               next_state = rs_transfer_state_pkg::fill;
            end
         end
         default: begin
            next_state = rs_transfer_state_pkg::idle;
         end
      endcase
   end

   // Moore outputs and counter enables
   always_comb begin
      datain_done  = 1'b0;
      dataoutstart = 1'b0;
      dataoutend   = 1'b0;
      shift_fifo   = 1'b0;
      hold_fifo    = 1'b0;
      en_infifo    = 1'b0;
      holdsynd     = 1'b0;
      cnt_in_en    = 1'b0;
      cnt_out_en   = 1'b0;
      case (state)
         rs_transfer_state_pkg::fill: begin
            shift_fifo = 1'b1;
            en_infifo  = 1'b1;
            cnt_in_en  = 1'b1;
         end
         rs_transfer_state_pkg::fill_last: begin
            shift_fifo  = 1'b1;
            en_infifo   = 1'b1;
            datain_done = 1'b1;
         end
         rs_transfer_state_pkg::hold: begin
            hold_fifo = 1'b1;
            holdsynd  = 1'b1;
         end
         rs_transfer_state_pkg::drain_start: begin
            hold_fifo  = 1'b1;
            cnt_out_en = 1'b1;
         end
         rs_transfer_state_pkg::drain_first: begin
            dataoutstart = 1'b1;
            shift_fifo   = 1'b1;
            cnt_out_en   = 1'b1;
         end
         rs_transfer_state_pkg::drain: begin
            shift_fifo = 1'b1;
            cnt_out_en = 1'b1;
         end
         rs_transfer_state_pkg::drain_end: begin
            dataoutend = 1'b1;
         end
         rs_transfer_state_pkg::overlap_start: begin
            dataoutstart = 1'b1;
            shift_fifo   = 1'b1;
            en_infifo    = 1'b1;
            cnt_in_en    = 1'b1;
            cnt_out_en   = 1'b1;
         end
         rs_transfer_state_pkg::overlap: begin
            shift_fifo = 1'b1;
            en_infifo  = 1'b1;
            cnt_in_en  = 1'b1;
            cnt_out_en = 1'b1;
         end
         rs_transfer_state_pkg::overlap_end_full: begin
            dataoutend  = 1'b1;
            shift_fifo  = 1'b1;
            en_infifo   = 1'b1;
            datain_done = 1'b1;
         end
         rs_transfer_state_pkg::overlap_end: begin
            dataoutend = 1'b1;
            shift_fifo = 1'b1;
            en_infifo  = 1'b1;
            cnt_in_en  = 1'b1;
         end
         default: begin
            cnt_in_en = 1'b0;
         end
      endcase
   end

   assert property (@(posedge clock1) disable iff (!reset)
      !(hold_fifo && shift_fifo));

   // Output end is a pulse, never a level
   assert property (@(posedge clock1) disable iff (!reset)
      dataoutend |=> !dataoutend);

endmodule

/* verilog/rs_decode_sequencer.sv */
`timescale 1ns/1ns

`include "rs_control_config.svh"

module rs_decode_sequencer (
   input  logic                        clock1,
   input  logic                        reset,
   input  logic                        start,
   input  logic                        datain_done,
   input  logic                        errdetect,
   input  logic                        finish_kes,
   input  logic                        dataoutend,
   input  logic [`RS_DEGREE_WIDTH-1:0] rootcntr,
   input  logic [`RS_DEGREE_WIDTH-1:0] lambda_degree,
   output logic                        ready,
   output logic                        active_sc,
   output logic                        active_kes,
   output logic                        active_csee,
   output logic                        evalsynd,
   output logic                        errfound,
   output logic                        decode_fail,
   output logic                        en_outfifo
);

   rs_decode_state_pkg::decode_state_t state;
   rs_decode_state_pkg::decode_state_t next_state;
   rs_decode_state_pkg::decode_state_t rx_resume;
   logic                               degree_match;
   logic                               datain_done_q;

   // Correction is good only if every locator root was found
   assign degree_match = (rootcntr == lambda_degree);

   // Overlapped reception may finish on the same cycle as the output
   assign rx_resume = datain_done ? rs_decode_state_pkg::syndrome
                                  : rs_decode_state_pkg::receive;

   always_ff @(posedge clock1 or negedge reset) begin
      if (!reset) begin
         state         <= rs_decode_state_pkg::idle;
         datain_done_q <= 1'b0;
      end else begin
         state         <= next_state;
         datain_done_q <= datain_done;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         rs_decode_state_pkg::idle: begin
            if (start) begin
               next_state = rs_decode_state_pkg::accept;
            end
         end
         rs_decode_state_pkg::accept: begin
            next_state = rs_decode_state_pkg::receive;
         end
         rs_decode_state_pkg::receive: begin
            if (datain_done) begin
               next_state = rs_decode_state_pkg::syndrome;
            end
         end
         rs_decode_state_pkg::syndrome: begin
            if (errdetect) begin
               next_state = rs_decode_state_pkg::kes_start;
            end else begin
               next_state = rs_decode_state_pkg::clean_output;
            end
         end
         rs_decode_state_pkg::kes_start: begin
            next_state = rs_decode_state_pkg::kes_wait;
         end
         rs_decode_state_pkg::kes_wait: begin
            if (finish_kes) begin
               next_state = rs_decode_state_pkg::correct;
            end
         end
         rs_decode_state_pkg::correct: begin
            next_state = rs_decode_state_pkg::output_word;
         end
         rs_decode_state_pkg::output_word: begin
            if (dataoutend) begin
               next_state = degree_match ? rs_decode_state_pkg::idle
                                         : rs_decode_state_pkg::fail_idle;
            end else if (start) begin
               next_state = rs_decode_state_pkg::output_rx_start;
            end
         end
         rs_decode_state_pkg::output_rx_start,
         rs_decode_state_pkg::output_rx: begin
            if (dataoutend) begin
               next_state = degree_match ? rx_resume : rs_decode_state_pkg::fail_rx;
            end else begin
               next_state = rs_decode_state_pkg::output_rx;
            end
         end
         rs_decode_state_pkg::fail_idle: begin
            next_state = start ? rs_decode_state_pkg::accept : rs_decode_state_pkg::idle;
         end
         rs_decode_state_pkg::fail_rx: begin
            // Catch a reception end that came with the last output symbol
            if (datain_done || datain_done_q) begin
               next_state = rs_decode_state_pkg::syndrome;
            end else begin
               next_state = rs_decode_state_pkg::receive;
            end
         end
         rs_decode_state_pkg::clean_output: begin
            if (dataoutend) begin
               next_state = rs_decode_state_pkg::idle;
            end else if (start) begin
               next_state = rs_decode_state_pkg::clean_rx_start;
            end
         end
         rs_decode_state_pkg::clean_rx_start,
         rs_decode_state_pkg::clean_rx: begin
            if (dataoutend) begin
               next_state = rx_resume;
            end else begin
               next_state = rs_decode_state_pkg::clean_rx;
            end
         end
         default: begin
            next_state = rs_decode_state_pkg::idle;
         end
      endcase
   end

   // Moore outputs
   always_comb begin
      ready       = 1'b1;
      active_sc   = 1'b0;
      active_kes  = 1'b0;
      active_csee = 1'b0;
      evalsynd    = 1'b0;
      errfound    = 1'b0;
      decode_fail = 1'b0;
      en_outfifo  = 1'b0;
      case (state)
         rs_decode_state_pkg::receive: begin
            active_sc = 1'b1;
         end
         rs_decode_state_pkg::syndrome: begin
            ready    = 1'b0;
            evalsynd = 1'b1;
         end
         rs_decode_state_pkg::kes_start: begin
            ready      = 1'b0;
            active_kes = 1'b1;
            errfound   = 1'b1;
         end
         rs_decode_state_pkg::kes_wait: begin
            ready      = 1'b0;
            active_kes = 1'b1;
         end
         rs_decode_state_pkg::correct: begin
            ready       = 1'b0;
            active_kes  = 1'b1;
            active_csee = 1'b1;
         end
         rs_decode_state_pkg::output_word,
         rs_decode_state_pkg::output_rx: begin
            active_kes = 1'b1;
            en_outfifo = 1'b1;
         end
         rs_decode_state_pkg::output_rx_start: begin
            active_sc  = 1'b1;
            active_kes = 1'b1;
            en_outfifo = 1'b1;
         end
         rs_decode_state_pkg::fail_idle,
         rs_decode_state_pkg::fail_rx: begin
            decode_fail = 1'b1;
         end
         rs_decode_state_pkg::clean_output,
         rs_decode_state_pkg::clean_rx: begin
            en_outfifo = 1'b1;
         end
         rs_decode_state_pkg::clean_rx_start: begin
            active_sc  = 1'b1;
            en_outfifo = 1'b1;
         end
         default: begin
            ready = 1'b1;
         end
      endcase
   end

   // Syndrome input and solver share time only while an old word drains
   assert property (@(posedge clock1) disable iff (!reset)
      (active_kes && active_sc) |-> (state inside {rs_decode_state_pkg::output_rx_start,
                                                   rs_decode_state_pkg::output_rx}));

   assert property (@(posedge clock1) disable iff (!reset)
      decode_fail |-> ready);

endmodule

/* verilog/rs_transfer_state_pkg.sv */
`include "rs_control_config.svh"

package rs_transfer_state_pkg;

   // Symbol transfer states between the FIFO and the decoder blocks
   typedef enum logic [3:0] {
      idle             = 4'd0,
      fill             = 4'd1,
      fill_last        = 4'd2,
      hold             = 4'd3,
      drain_start      = 4'd4,
      drain_first      = 4'd5,
      drain            = 4'd6,
      drain_end        = 4'd7,
      overlap_start    = 4'd8,
      overlap          = 4'd9,
      overlap_end_full = 4'd10,
      overlap_end      = 4'd11
   } transfer_state_t;

   // Position of a symbol inside the codeword
   typedef logic [`RS_CNT_WIDTH-1:0] symbol_count_t;

endpackage

/* verilog/rs_decode_state_pkg.sv */
package rs_decode_state_pkg;

   // One state per step of the decode of a codeword
   // Names ending in _rx overlap reception of the next word with output
   typedef enum logic [3:0] {
      idle            = 4'd0,
      accept          = 4'd1,
      receive         = 4'd2,
      syndrome        = 4'd3,
      kes_start       = 4'd4,
      kes_wait        = 4'd5,
      correct         = 4'd6,
      output_word     = 4'd7,
      output_rx_start = 4'd8,
      output_rx       = 4'd9,
      fail_idle       = 4'd10,
      fail_rx         = 4'd11,
      clean_output    = 4'd12,
      clean_rx_start  = 4'd13,
      clean_rx        = 4'd14
   } decode_state_t;

endpackage

/* include/rs_control_config.svh */
`ifndef RS_CONTROL_CONFIG_SVH
`define RS_CONTROL_CONFIG_SVH

// Symbols per codeword
`define RS_WORD_LEN 31

// Width of both symbol counters
`define RS_CNT_WIDTH 5

// Input count of the last received symbol
`define RS_DATAIN_LAST (`RS_WORD_LEN - 1)

// Output count of the last corrected symbol, counter all ones
`define RS_DATAOUT_LAST ((1 << `RS_CNT_WIDTH) - 1)

// Width of root count and locator degree
`define RS_DEGREE_WIDTH 3

`endif
